//--- all.f
logic/board_pkg.sv
logic/mem_pkg.sv
logic/support_timer.sv
logic/support_seq.sv
logic/mem_store.sv
logic/mem_arbiter.sv
logic/led_status.sv
logic/board_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- logic/board_pkg.sv
// Board control types: sequencer states, hold and debounce lengths, LED views
package board_pkg;

   //////////////////////////////
   // Support sequencer
   //////////////////////////////

   // Fixed codes, these show up on the LEDs
   typedef enum logic [2:0] {
      st_reset = 3'd0,   // Local reset held
      st_calib = 3'd1,   // Memory clearing
      st_boot  = 3'd2,   // One cycle boot pulse
      st_run   = 3'd3,
      st_halt  = 3'd4
   } seq_state_t;

   localparam int RESET_HOLD   = 8;   // Cycles in st_reset
   localparam int DEBOUNCE_LEN = 4;   // Cycles high for a press

   // Counter widths
   localparam int HOLD_W     = $clog2(RESET_HOLD + 1);
   localparam int DEBOUNCE_W = $clog2(DEBOUNCE_LEN + 1);

   //////////////////////////////
   // LED status
   //////////////////////////////

   // Switch selected view
   typedef enum logic [1:0] {
      view_state = 2'd0,
      view_count = 2'd1,
      view_addr  = 2'd2,
      view_data  = 2'd3
   } led_view_t;

   // State view layout, MSB first
   typedef struct packed {
      logic [10:0] zero_hi;      // Unused LEDs
      logic        calib_done;   // LED 4
      logic        zero_lo;      // LED 3
      seq_state_t  state;        // LEDs 2..0
   } led_state_view_t;

endpackage

//--- logic/board_top.sv
// Board top: support timer and sequencer, memory arbiter and store, LED status
module board_top (
   input  logic              main_clk,
   input  logic              rst_n,
   input  logic              button_r,
   input  logic              button_h,
   input  logic [1:0]        switch,
   input  mem_pkg::mem_req_t sdram_req,
   input  mem_pkg::mem_req_t vram_cpu_req,
   input  mem_pkg::mem_req_t vram_vga_req,
   output mem_pkg::mem_rsp_t sdram_rsp,
   output mem_pkg::mem_rsp_t vram_cpu_rsp,
   output mem_pkg::mem_rsp_t vram_vga_rsp,
   output logic [15:0]       led
);

   // Support
   logic                  hold_start;
   logic                  hold_expired;
   logic                  press_r;
   logic                  press_h;
   logic                  dram_reset;
   board_pkg::seq_state_t state;
   // Memory
   logic                  calib_done;
   mem_pkg::store_cmd_t   cmd;
   logic [31:0]           rdata;
   mem_pkg::mem_port_t    rtag;
   logic                  rvalid;
   mem_pkg::mem_port_t    grant_port;
   logic                  grant;
   logic                  done_any;
   logic [31:0]           done_data;

   // At most one done per cycle
   assign done_any  = sdram_rsp.done | vram_cpu_rsp.done | vram_vga_rsp.done;
   assign done_data = sdram_rsp.done    ? sdram_rsp.rdata    :
                      vram_cpu_rsp.done ? vram_cpu_rsp.rdata : vram_vga_rsp.rdata;

   support_timer u_timer (.main_clk, .rst_n, .hold_start, .hold_expired,
                          .button_r, .button_h, .press_r, .press_h);

   // Boot, run and halt go to the processor core, not fitted here
   support_seq u_seq (.main_clk, .rst_n, .hold_expired, .press_r, .press_h, .calib_done,
                      .hold_start, .dram_reset, .boot(), .machrun(), .halt(), .state);

   mem_store u_store (.main_clk, .rst_n, .dram_reset, .cmd, .rdata, .rtag, .rvalid,
                      .calib_done);

   mem_arbiter u_arb (.main_clk, .rst_n, .calib_done, .sdram_req, .vram_cpu_req,
                      .vram_vga_req, .sdram_rsp, .vram_cpu_rsp, .vram_vga_rsp, .cmd,
                      .rdata, .rtag, .rvalid, .grant_port, .grant);

   led_status u_led (.main_clk, .rst_n, .switch(board_pkg::led_view_t'(switch)), .state,
                     .calib_done, .grant, .grant_port, .cmd, .done_data, .done_any, .led);

endmodule

//--- logic/led_status.sv
// LED status: per-port grant counters, last access registers, switch-selected LED word
module led_status (
   input  logic                  main_clk,
   input  logic                  rst_n,
   input  board_pkg::led_view_t  switch,
   input  board_pkg::seq_state_t state,
   input  logic                  calib_done,
   input  logic                  grant,
   input  mem_pkg::mem_port_t    grant_port,
   input  mem_pkg::store_cmd_t   cmd,
   input  logic [31:0]           done_data,
   input  logic                  done_any,
   output logic [15:0]           led
);

   localparam int NP = mem_pkg::NUM_PORTS;

   logic [15:0]                 port_cnt [NP];   // Grants per port, wrapping
   logic [15:0]                 total_cnt;
   logic [mem_pkg::MEM_AW-1:0]  last_addr;       // Store word of last grant
   logic [15:0]                 last_data;
   board_pkg::led_state_view_t  st_view;

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         last_addr <= '0;
         last_data <= '0;
         for (int i = 0; i < NP; i++) begin
            port_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NP; i++) begin
            if (grant && grant_port == mem_pkg::mem_port_t'(i)) begin
               port_cnt[i] <= port_cnt[i] + 1'b1;
            end
         end
         if (grant) last_addr <= cmd.addr;
         if (done_any) last_data <= done_data[15:0];   // Low half only shown
      end
   end

   assign total_cnt = port_cnt[0] + port_cnt[1] + port_cnt[2];

   // View select
   always_comb begin
      st_view            = '0;
      st_view.calib_done = calib_done;
      st_view.state      = state;
      case (switch)
         board_pkg::view_state: led = st_view;
         board_pkg::view_count: led = total_cnt;
         board_pkg::view_addr:  led = 16'(last_addr);
         board_pkg::view_data:  led = last_data;
         default:               led = '0;
      endcase
   end

endmodule

//--- logic/mem_arbiter.sv
// Fixed-priority grant of three memory ports, store command register, tagged return routing
module mem_arbiter (
   input  logic                main_clk,
   input  logic                rst_n,
   input  logic                calib_done,
   input  mem_pkg::mem_req_t   sdram_req,
   input  mem_pkg::mem_req_t   vram_cpu_req,
   input  mem_pkg::mem_req_t   vram_vga_req,
   output mem_pkg::mem_rsp_t   sdram_rsp,
   output mem_pkg::mem_rsp_t   vram_cpu_rsp,
   output mem_pkg::mem_rsp_t   vram_vga_rsp,
   output mem_pkg::store_cmd_t cmd,
   input  logic [31:0]         rdata,
   input  mem_pkg::mem_port_t  rtag,
   input  logic                rvalid,
   output mem_pkg::mem_port_t  grant_port,
   output logic                grant
);

   localparam int NP = mem_pkg::NUM_PORTS;
   localparam int AW = mem_pkg::MEM_AW;

   mem_pkg::mem_req_t   req_a [NP];     // By port code
   logic [NP-1:0]       elig;
   mem_pkg::mem_port_t  pick_port;
   mem_pkg::store_cmd_t cmd_nxt;
   logic [NP-1:0]       done_q;
   logic [31:0]         rdata_q [NP];   // Last return per port

   // Port address to store word
   function automatic logic [AW-1:0] map_addr(input mem_pkg::mem_port_t port,
                                              input logic [mem_pkg::ADDR_W-1:0] addr);
      logic [AW-1:0] word;
      word = AW'(addr[mem_pkg::WIN_AW-1:0]);
      if (port != mem_pkg::port_sdram) begin
         word = word + AW'(mem_pkg::VRAM_BASE);   // Video window
      end
      return word;
   endfunction

   assign req_a[mem_pkg::port_sdram]    = sdram_req;
   assign req_a[mem_pkg::port_vram_cpu] = vram_cpu_req;
   assign req_a[mem_pkg::port_vram_vga] = vram_vga_req;

   //////////////////////////////
   // Grant
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < NP; i++) begin
         // Port granted last cycle still shows req, skip it once
         elig[i] = req_a[i].req && calib_done &&
                   !(cmd.en && cmd.tag == mem_pkg::mem_port_t'(i));
      end
      pick_port = mem_pkg::port_sdram;
      if (elig[mem_pkg::port_vram_vga]) begin
         pick_port = mem_pkg::port_vram_vga;
      end else if (elig[mem_pkg::port_vram_cpu]) begin
         pick_port = mem_pkg::port_vram_cpu;
      end
      cmd_nxt.en    = |elig;
      cmd_nxt.write = req_a[pick_port].write && (pick_port != mem_pkg::port_vram_vga);
      cmd_nxt.addr  = map_addr(pick_port, req_a[pick_port].addr);
      cmd_nxt.wdata = req_a[pick_port].wdata;
      cmd_nxt.tag   = pick_port;
   end

   //////////////////////////////
   // Command and return registers
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd    <= '0;
         done_q <= '0;
      end else begin
         cmd <= cmd_nxt;
         for (int i = 0; i < NP; i++) begin
            done_q[i] <= rvalid && (rtag == mem_pkg::mem_port_t'(i));
         end
      end
   end

   always_ff @(posedge main_clk) begin
      if (rvalid) begin
         rdata_q[rtag] <= rdata;
      end
   end

   // Ready is the registered grant
   assign grant      = cmd.en;
   assign grant_port = cmd.tag;

   always_comb begin
      sdram_rsp.ready    = cmd.en && (cmd.tag == mem_pkg::port_sdram);
      sdram_rsp.done     = done_q[mem_pkg::port_sdram];
      sdram_rsp.rdata    = rdata_q[mem_pkg::port_sdram];
      vram_cpu_rsp.ready = cmd.en && (cmd.tag == mem_pkg::port_vram_cpu);
      vram_cpu_rsp.done  = done_q[mem_pkg::port_vram_cpu];
      vram_cpu_rsp.rdata = rdata_q[mem_pkg::port_vram_cpu];
      vram_vga_rsp.ready = cmd.en && (cmd.tag == mem_pkg::port_vram_vga);
      vram_vga_rsp.done  = done_q[mem_pkg::port_vram_vga];
      vram_vga_rsp.rdata = rdata_q[mem_pkg::port_vram_vga];
   end

endmodule

//--- logic/mem_pkg.sv
// Memory port enum, request/response and store command structs, store geometry
package mem_pkg;

   // Store geometry
   localparam int MEM_AW    = 10;
   localparam int MEM_WORDS = 1 << MEM_AW;
   localparam int MEM_LAT   = 2;     // RAM read stage plus output stage
   localparam int WIN_AW    = 9;     // Each port window is 512 words
   localparam int VRAM_BASE = 512;   // Video window start word

   // Port bus widths
   localparam int ADDR_W    = 22;
   localparam int DATA_W    = 32;
   localparam int NUM_PORTS = 3;

   typedef enum logic [1:0] {
      port_sdram    = 2'd0,   // CPU main memory
      port_vram_cpu = 2'd1,   // CPU video memory
      port_vram_vga = 2'd2    // Display read, highest priority
   } mem_port_t;

   // Requester side, plain strobes
   typedef struct packed {
      logic              req;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              ready;   // Grant pulse
      logic              done;    // MEM_LAT+1 after ready
      logic [DATA_W-1:0] rdata;
   } mem_rsp_t;

   // Arbiter to store, tag rides along
   typedef struct packed {
      logic              en;
      logic              write;
      logic [MEM_AW-1:0] addr;
      logic [DATA_W-1:0] wdata;
      mem_port_t         tag;
   } store_cmd_t;

endpackage

//--- logic/mem_store.sv
// Backing word RAM with calibration clear and a tagged two-stage read path
module mem_store (
   input  logic                main_clk,
   input  logic                rst_n,
   input  logic                dram_reset,
   input  mem_pkg::store_cmd_t cmd,
   output logic [31:0]         rdata,
   output mem_pkg::mem_port_t  rtag,
   output logic                rvalid,
   output logic                calib_done
);

   localparam int LAT = mem_pkg::MEM_LAT;
   localparam int AW  = mem_pkg::MEM_AW;

   logic [mem_pkg::DATA_W-1:0] mem [mem_pkg::MEM_WORDS];
   logic [AW-1:0]              clr_ptr;
   logic [LAT-1:0]             pipe_valid;
   logic [LAT-1:0]             pipe_write;       // Writes return zero
   logic [31:0]                pipe_data [LAT];
   mem_pkg::mem_port_t         pipe_tag  [LAT];

   //////////////////////////////
   // Calibration clear
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         clr_ptr    <= '0;
         calib_done <= 1'b0;
      end else if (dram_reset) begin
         clr_ptr    <= '0;                   // Held until released
         calib_done <= 1'b0;
      end else if (!calib_done) begin
         clr_ptr <= clr_ptr + 1'b1;
         if (&clr_ptr) begin
            calib_done <= 1'b1;              // Last word written this cycle
         end
      end
   end

   // Single write port, clear has it until calibrated
   always_ff @(posedge main_clk) begin
      if (!calib_done) begin
         mem[clr_ptr] <= '0;
      end else if (cmd.en && cmd.write) begin
         mem[cmd.addr] <= cmd.wdata;
      end
   end

   //////////////////////////////
   // Read pipeline
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= cmd.en;
         for (int i = 1; i < LAT; i++) begin
            pipe_valid[i] <= pipe_valid[i-1];
         end
      end
   end

   always_ff @(posedge main_clk) begin
      pipe_data[0]  <= mem[cmd.addr];        // RAM read stage
      pipe_write[0] <= cmd.write;
      pipe_tag[0]   <= cmd.tag;
      for (int i = 1; i < LAT; i++) begin
         pipe_data[i]  <= pipe_data[i-1];
         pipe_write[i] <= pipe_write[i-1];
         pipe_tag[i]   <= pipe_tag[i-1];
      end
   end

   assign rdata  = pipe_write[LAT-1] ? '0 : pipe_data[LAT-1];
   assign rtag   = pipe_tag[LAT-1];
   assign rvalid = pipe_valid[LAT-1];

endmodule

//--- logic/support_seq.sv
// Support state machine: reset hold, calibration wait, boot pulse, run and halt
module support_seq (
   input  logic                  main_clk,
   input  logic                  rst_n,
   input  logic                  hold_expired,
   input  logic                  press_r,
   input  logic                  press_h,
   input  logic                  calib_done,
   output logic                  hold_start,
   output logic                  dram_reset,
   output logic                  boot,
   output logic                  machrun,
   output logic                  halt,
   output board_pkg::seq_state_t state
);

   board_pkg::seq_state_t state_nxt;
   logic                  hold_armed;   // Countdown started for this stay in st_reset

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         board_pkg::st_reset: begin
            // Only a countdown started in this stay counts
            if (hold_armed && hold_expired) begin
               state_nxt = board_pkg::st_calib;
            end
         end
         board_pkg::st_calib: begin
            if (calib_done) begin
               state_nxt = board_pkg::st_boot;
            end
         end
         board_pkg::st_boot: state_nxt = board_pkg::st_run;   // Single cycle
         board_pkg::st_run: begin
            if (press_h) begin
               state_nxt = board_pkg::st_halt;
            end
         end
         board_pkg::st_halt: begin
            if (press_h) begin
               state_nxt = board_pkg::st_run;
            end
         end
         default: state_nxt = board_pkg::st_reset;
      endcase
      if (press_r) begin
         state_nxt = board_pkg::st_reset;   // Wins from any state
      end
   end

   //////////////////////////////
   // State and hold tracking
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= board_pkg::st_reset;
         hold_armed <= 1'b0;
      end else begin
         state      <= state_nxt;
         // Re-press inside st_reset restarts the hold
         hold_armed <= (state == board_pkg::st_reset) &&
                       (state_nxt == board_pkg::st_reset) && !press_r;
      end
   end

   // Outputs decoded from state
   assign hold_start = (state == board_pkg::st_reset) && !hold_armed;   // Entry pulse
   assign dram_reset = (state == board_pkg::st_reset);
   assign boot       = (state == board_pkg::st_boot);
   assign machrun    = (state == board_pkg::st_run);
   assign halt       = (state == board_pkg::st_halt);

endmodule

//--- logic/support_timer.sv
// Reset hold countdown and debounce counters for the reset and halt buttons
module support_timer (
   input  logic main_clk,
   input  logic rst_n,
   input  logic hold_start,
   output logic hold_expired,
   input  logic button_r,
   input  logic button_h,
   output logic press_r,
   output logic press_h
);

   localparam int HW = board_pkg::HOLD_W;
   localparam int DW = board_pkg::DEBOUNCE_W;

   logic [HW-1:0] hold_cnt;      // Cycles left, zero when idle
   logic [1:0]    btn_meta;      // Bit 0 reset button, bit 1 halt button
   logic [1:0]    btn_sync;
   logic [DW-1:0] deb_cnt [2];   // Saturates at DEBOUNCE_LEN
   logic [1:0]    press_q;

   //////////////////////////////
   // Reset hold
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_cnt <= '0;
      end else if (hold_start) begin
         hold_cnt <= HW'(board_pkg::RESET_HOLD - 1);   // Start cycle counts as one
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 1'b1;
      end
   end

   assign hold_expired = (hold_cnt == HW'(1));   // Last hold cycle

   //////////////////////////////
   // Button debounce
   //////////////////////////////

   always_ff @(posedge main_clk or negedge rst_n) begin
      if (!rst_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
         press_q  <= '0;
         for (int i = 0; i < 2; i++) begin
            deb_cnt[i] <= '0;
         end
      end else begin
         btn_meta <= {button_h, button_r};   // Buttons are asynchronous
         btn_sync <= btn_meta;
         for (int i = 0; i < 2; i++) begin
            press_q[i] <= 1'b0;
            if (!btn_sync[i]) begin
               deb_cnt[i] <= '0;             // Release unlocks
            end else if (deb_cnt[i] != DW'(board_pkg::DEBOUNCE_LEN)) begin
               deb_cnt[i] <= deb_cnt[i] + 1'b1;
               // Fires once, on the step into saturation
               press_q[i] <= (deb_cnt[i] == DW'(board_pkg::DEBOUNCE_LEN - 1));
            end
         end
      end
   end

   assign press_r = press_q[0];
   assign press_h = press_q[1];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   -f all.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with an error"
   exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
   exit 0
fi
exit 1

//--- tests/board_trace.txt
# cmd: wait n | press R H S(short halt) | write port addr data | read port addr exp
# cmd: view switch led | all | burst rounds   (port 0 sdram, 1 video cpu, 2 display)
wait 12
view 0 0001
read 0 005 00000000
view 0 0013
write 0 010 cafe0001
read 0 010 cafe0001
write 1 010 beef0002
read 2 010 beef0002
read 0 010 cafe0001
write 1 1ff 12345678
read 2 1ff 12345678
read 1 1ff 12345678
write 0 1ff 0badf00d
read 0 1ff 0badf00d
view 3 f00d
view 2 01ff
view 1 000b
all
burst 20
press H
view 0 0014
press S
view 0 0014
press H
view 0 0013
press R
read 0 010 00000000
read 2 010 00000000
read 1 1ff 00000000
view 0 0013

//--- tests/tb_checker.sv
// Store model, grant order, done timing and LED view checks
module tb_checker (
   input logic              main_clk,
   input logic              rst_n,
   input logic              calib_done,
   input mem_pkg::mem_req_t req [3],
   input mem_pkg::mem_rsp_t rsp [3],
   input logic [15:0]       led
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic [1:0]  port;
      int          cyc;      // Negedge count when done is due
      logic [31:0] data;
      logic        has_tr;   // Trace value attached
      logic [31:0] tr;
   } done_t;

   logic [31:0]       model [1024];   // Store words
   done_t             done_q [$];
   mem_pkg::mem_req_t prev_q [3];
   logic              prev_calib;
   logic [2:0]        prev_rdy;
   logic [2:0]        tr_valid;
   logic [31:0]       tr_data [3];
   logic [15:0]       last_addr;
   logic [15:0]       last_data;
   int                mismatches;
   int                cyc;
   int                grants;

   initial begin
      mismatches = 0;
      cyc        = 0;
      grants     = 0;
      last_addr  = '0;
      last_data  = '0;
      tr_valid   = '0;
      for (int i = 0; i < 1024; i++) begin
         model[i] = '0;
      end
   end

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %0s: got %h expected %h", name, got, exp);
      end
   endtask

   // Called by the trace reader
   task automatic expect_read(input int p, input logic [31:0] data);
      tr_valid[p] = 1'b1;
      tr_data[p]  = data;
   endtask

   task automatic clear_model();
      for (int i = 0; i < 1024; i++) begin
         model[i] = '0;   // Reset press clears the store
      end
   endtask

   task automatic check_view(input logic [1:0] sw, input logic [15:0] exp);
      report_value("led", 32'(led), 32'(exp));
      case (sw)
         2'd1: report_value("led count", 32'(led), 32'(grants[15:0]));
         2'd2: report_value("led addr", 32'(led), 32'(last_addr));
         2'd3: report_value("led data", 32'(led), 32'(last_data));
         default: ;
      endcase
   endtask

   ////////////////////////////////
   // Per-cycle watch
   ////////////////////////////////

   always @(negedge main_clk) begin : watch
      int          exp_p;
      logic [2:0]  exp_rdy;
      logic [2:0]  exp_done;
      logic [9:0]  word;
      logic        wr;
      done_t       ent;
      cyc = cyc + 1;
      if (!rst_n) begin
         prev_calib = 1'b0;
         prev_rdy   = '0;
         for (int p = 0; p < 3; p++) begin
            prev_q[p] = '0;
         end
      end else begin
         // Grant decided on last cycle's requests
         exp_p = -1;
         for (int p = 2; p >= 0; p--) begin
            if (exp_p < 0 && prev_q[p].req && prev_calib && !prev_rdy[p]) begin
               exp_p = p;   // vga, then video cpu, then sdram
            end
         end
         exp_rdy = '0;
         if (exp_p >= 0) exp_rdy[exp_p] = 1'b1;
         for (int p = 0; p < 3; p++) begin
            report_value($sformatf("rsp[%0d].ready", p), 32'(rsp[p].ready),
                         32'(exp_rdy[p]));
         end
         if (exp_p >= 0) begin
            word = 10'(prev_q[exp_p].addr[8:0]);
            if (exp_p != 0) word = word + 10'(mem_pkg::VRAM_BASE);   // Video window
            wr = prev_q[exp_p].write && (exp_p != 2);   // Display port reads only
            ent.port   = 2'(exp_p);
            ent.cyc    = cyc + 3;
            ent.has_tr = tr_valid[exp_p] && !wr;
            ent.tr     = tr_data[exp_p];
            if (!wr) tr_valid[exp_p] = 1'b0;
            if (wr) begin
               model[word] = prev_q[exp_p].wdata;
               ent.data    = '0;   // Write done carries zero
            end else begin
               ent.data = model[word];
            end
            grants++;
            last_addr = 16'(word);
            done_q.push_back(ent);
         end
         // Done exactly three cycles after ready
         exp_done = '0;
         if (done_q.size() > 0 && done_q[0].cyc == cyc) begin
            ent = done_q.pop_front();
            exp_done[ent.port] = 1'b1;
            report_value($sformatf("rsp[%0d].rdata", ent.port), rsp[ent.port].rdata,
                         ent.data);
            if (ent.has_tr) begin
               report_value($sformatf("rsp[%0d].rdata trace", ent.port),
                            rsp[ent.port].rdata, ent.tr);
            end
            last_data = ent.data[15:0];
         end
         for (int p = 0; p < 3; p++) begin
            report_value($sformatf("rsp[%0d].done", p), 32'(rsp[p].done),
                         32'(exp_done[p]));
         end
         prev_q     = req;
         prev_calib = calib_done;
         prev_rdy   = exp_rdy;
      end
   end

endmodule

//--- tests/tb_clock.sv
// Testbench clock and power-on reset generator
module tb_clock (
   output logic main_clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      main_clk = 1'b0;
      forever #4 main_clk = ~main_clk;   // 8 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge main_clk);   // Reset held 16 cycles
      #1 rst_n = 1'b1;
   end

endmodule

//--- tests/tb_top.sv
// Testbench top with trace reader, button, switch and port drivers, DUT and checker
module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   logic              main_clk;
   logic              rst_n;
   logic              button_r;
   logic              button_h;
   logic [1:0]        switch;
   mem_pkg::mem_req_t reqs [3];   // 0 sdram, 1 video cpu, 2 display
   mem_pkg::mem_rsp_t rsps [3];
   logic [15:0]       led;
   int                faults;     // Timeouts and trace errors

   tb_clock u_clk (.main_clk, .rst_n);

   board_top u_dut (
      .main_clk, .rst_n, .button_r, .button_h, .switch,
      .sdram_req(reqs[0]), .vram_cpu_req(reqs[1]), .vram_vga_req(reqs[2]),
      .sdram_rsp(rsps[0]), .vram_cpu_rsp(rsps[1]), .vram_vga_rsp(rsps[2]),
      .led
   );

   tb_checker u_chk (.main_clk, .rst_n, .calib_done(u_dut.calib_done),
                     .req(reqs), .rsp(rsps), .led);

   // One access on one port through ready and done
   task automatic port_access(input int p, input logic wr, input logic [21:0] addr,
                              input logic [31:0] data);
      int n;
      @(posedge main_clk);
      #1;
      reqs[p].req   = 1'b1;
      reqs[p].write = wr;
      reqs[p].addr  = addr;
      reqs[p].wdata = data;
      n = 0;
      @(negedge main_clk);
      while (!rsps[p].ready && n < 3000) begin   // Covers a full clear
         @(negedge main_clk);
         n++;
      end
      if (!rsps[p].ready) begin
         faults++;
         $display("Timeout: port %0d saw no ready", p);
         reqs[p].req = 1'b0;
         return;
      end
      @(posedge main_clk);
      #1 reqs[p].req = 1'b0;
      n = 0;
      @(negedge main_clk);
      while (!rsps[p].done && n < 8) begin
         @(negedge main_clk);
         n++;
      end
      if (!rsps[p].done) begin
         faults++;
         $display("Timeout: port %0d saw no done", p);
      end
   endtask

   // Ports in mask start in the same cycle
   task automatic run_group(input logic [2:0] mask, input logic [2:0] wr,
                            input logic [21:0] a0, input logic [21:0] a1,
                            input logic [21:0] a2, input logic [31:0] d0,
                            input logic [31:0] d1, input logic [31:0] d2);
      fork
         if (mask[0]) port_access(0, wr[0], a0, d0);
         if (mask[1]) port_access(1, wr[1], a1, d1);
         if (mask[2]) port_access(2, wr[2], a2, d2);   // Display write is ignored
      join
   endtask

   task automatic press_button(input logic halt_btn, input int len);
      @(posedge main_clk);
      #1;
      if (halt_btn) button_h = 1'b1;
      else button_r = 1'b1;
      repeat (len) @(posedge main_clk);
      #1;
      button_h = 1'b0;
      button_r = 1'b0;
      repeat (8) @(posedge main_clk);   // Release gap
   endtask

   task automatic random_bursts(input int rounds);
      logic [2:0] mask;
      for (int r = 0; r < rounds; r++) begin
         mask = 3'($urandom_range(1, 7));
         // Low window words stay clear of the directed addresses
         run_group(mask, 3'($urandom_range(0, 7)),
                   22'(32'h20 + $urandom_range(0, 'hdf)),
                   22'(32'h20 + $urandom_range(0, 'hdf)),
                   22'(32'h20 + $urandom_range(0, 'hdf)), $urandom, $urandom, $urandom);
         repeat ($urandom_range(0, 3)) @(posedge main_clk);   // Idle gap
      end
   endtask

   initial begin : main
      int               fd;
      int               code;
      int               n;
      int               p;
      logic [31:0]      a;
      logic [31:0]      d;
      logic [8*8-1:0]   word;
      logic [8*8-1:0]   arg;
      logic [8*128-1:0] line_buf;
      button_r = 1'b0;
      button_h = 1'b0;
      switch   = 2'd0;
      faults   = 0;
      for (int i = 0; i < 3; i++) begin
         reqs[i] = '0;
      end
      void'($urandom(32'hd2fe_9cf0));
      fd = $fopen("tests/board_trace.txt", "r");
      if (fd == 0) begin
         faults++;
         $display("Could not open the trace file");
      end
      n = 0;
      while (!rst_n && n < 100) begin
         @(posedge main_clk);
         n++;
      end
      if (!rst_n) begin
         faults++;
         $display("Timeout: reset never released");
      end
      ////////////////////////////////
      // Trace commands
      ////////////////////////////////
      while (fd != 0 && faults == 0) begin
         code = $fscanf(fd, "%s", word);
         if (code != 1) break;
         if (word == "#") begin
            void'($fgets(line_buf, fd));   // Comment line
         end else if (word == "wait") begin
            code = $fscanf(fd, "%d", n);
            repeat (n) @(posedge main_clk);
         end else if (word == "press") begin
            code = $fscanf(fd, "%s", arg);
            if (arg == "R") begin
               press_button(1'b0, 8);
               u_chk.clear_model();
            end else if (arg == "H") begin
               press_button(1'b1, 8);
            end else begin
               press_button(1'b1, board_pkg::DEBOUNCE_LEN - 1);   // Too short to count
            end
         end else if (word == "write") begin
            code = $fscanf(fd, "%d %h %h", p, a, d);
            port_access(p, 1'b1, a[21:0], d);
         end else if (word == "read") begin
            code = $fscanf(fd, "%d %h %h", p, a, d);
            u_chk.expect_read(p, d);
            port_access(p, 1'b0, a[21:0], '0);
         end else if (word == "view") begin
            code = $fscanf(fd, "%d %h", p, d);
            @(posedge main_clk);
            #1 switch = 2'(p);
            @(negedge main_clk);
            @(negedge main_clk);
            u_chk.check_view(2'(p), d[15:0]);
         end else if (word == "all") begin
            run_group(3'b111, 3'b000, 22'h010, 22'h010, 22'h1ff, '0, '0, '0);
         end else if (word == "burst") begin
            code = $fscanf(fd, "%d", n);
            random_bursts(n);
         end else begin
            faults++;
            $display("Unknown command in trace file");
         end
      end
      if (fd != 0) $fclose(fd);
      repeat (6) @(posedge main_clk);   // Let the last done drain
      $display("errors: mismatches=%0d faults=%0d", u_chk.mismatches, faults);
      if (u_chk.mismatches == 0 && faults == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
